// File: tb.f
verilog/i2s_pkg.sv
verilog/sample_fetch_if.sv
verilog/i2s_sync.sv
verilog/i2s_deserializer.sv
verilog/sample_fifo.sv
verilog/serializer.sv
verilog/i2s_passthrough_top.sv
dv/i2s_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the I2S pass-through testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module i2s_tb -f tb.f -o i2s_tb_sim

# A fatal stop returns nonzero, the log decides the result
./obj_dir/i2s_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "Run passed"
    exit 0
else
    echo "Run did not pass, see sim.log"
    exit 1
fi

// File: dv/i2s_tb.sv
module i2s_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import i2s_pkg::*;

    localparam int NUM_LIVE     = 44;                   // Pairs checked once audio shows up
    localparam int MAX_SILENT   = 6;                    // Silent frames allowed before audio
    localparam int FRAME_WAIT   = 200 * 8;              // 200 bit clocks in clk cycles
    localparam int PARTIAL_BITS = 6;                    // Tail of a right word before lock

    logic clk = 1'b0;
    logic rst_n;
    logic i2si_sck;
    logic i2si_ws;
    logic i2si_sd;
    logic i2so_sck;
    logic i2so_ws;
    logic i2so_sd;

    audio_word_t sent_lft_q [$];                        // Pairs in send order
    audio_word_t sent_rgt_q [$];
    audio_word_t dec_lft_q [$];                         // Frames seen on the output
    audio_word_t dec_rgt_q [$];
    int          first_live = -1;                       // Frame index of first audio

    // Output decoder state
    logic        dec_locked  = 1'b0;
    logic        dec_ws_prev = 1'b0;
    channel_e    dec_chan    = LEFT;
    int          dec_bits    = 0;
    audio_word_t dec_sr      = '0;
    audio_word_t dec_lft     = '0;

    always #20 clk = ~clk;                              // 40 ns period

    i2s_passthrough_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .i2si_sck (i2si_sck),
        .i2si_ws  (i2si_ws),
        .i2si_sd  (i2si_sd),
        .i2so_sck (i2so_sck),
        .i2so_ws  (i2so_ws),
        .i2so_sd  (i2so_sd)
    );

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_word(input string name, input audio_word_t got, input audio_word_t exp);
        if (got !== exp)
        begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_ws(input logic got, input channel_e exp);
        if (got !== (exp == RIGHT))
        begin
            $display("error at %0t: i2so_ws got %b expected %b", $time, got, (exp == RIGHT));
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Silence until first audio and then the sent pairs in order
    function automatic void expected_pair(input int frame, output audio_word_t l,
                                          output audio_word_t r);
        int idx;
        idx = frame - first_live;
        l   = '0;
        r   = '0;
        if ((first_live >= 0) && (idx >= 0))
        begin
            l = (idx < sent_lft_q.size()) ? sent_lft_q[idx] : 'x;  // Never sent
            r = (idx < sent_rgt_q.size()) ? sent_rgt_q[idx] : 'x;
        end
    endfunction

    ////////////////////
    // Stimulus
    ////////////////////

    // One bit with ws and sd changed on the falling bit clock
    task automatic send_bit(input logic ws, input logic sd);
        @(posedge clk);
        i2si_sck <= 1'b0;
        i2si_ws  <= ws;
        i2si_sd  <= sd;
        repeat (4) @(posedge clk);
        i2si_sck <= 1'b1;
        repeat (3) @(posedge clk);
    endtask

    // MSB first with ws flipping on the LSB
    task automatic send_word(input channel_e chan, input audio_word_t word);
        for (int i = WORD_BITS - 1; i >= 0; i--)
            send_bit((i == 0) ? (chan == LEFT) : (chan == RIGHT), word[i]);
    endtask

    task automatic stream_audio();
        logic [31:0] rnd;
        audio_word_t l;
        audio_word_t r;
        int          k;
        // Tail of a right word with ws already high that must never come out
        for (int i = PARTIAL_BITS - 1; i >= 0; i--)
            send_bit(i != 0, 1'b1);
        k = 0;
        forever
        begin
            rnd = $urandom();
            l   = rnd[15:0];
            r   = rnd[31:16];
            if (k == 0)
                l = l | 16'h0001;                       // First pair is never silent
            case (k)
                5:  {l, r} = {16'h8000, 16'h7fff};
                12: {l, r} = {16'h7fff, 16'h8000};
                20: {l, r} = {16'h0000, 16'h8000};
                27: {l, r} = {16'h0000, 16'h0000};
                default: ;
            endcase
            sent_lft_q.push_back(l);
            sent_rgt_q.push_back(r);
            send_word(LEFT, l);
            send_word(RIGHT, r);
            k++;
        end
    endtask

    ////////////////////
    // Output decoder
    ////////////////////

    always @(posedge i2so_sck)
    begin
        dec_sr = {dec_sr[WORD_BITS-2:0], i2so_sd};
        if (!dec_locked)
        begin
            // Only the last 16 bits form the first left word
            if (i2so_ws != dec_ws_prev)
            begin
                dec_locked = 1'b1;
                dec_lft    = dec_sr;
                dec_chan   = RIGHT;
                dec_bits   = 0;
            end
            else
                check_ws(i2so_ws, LEFT);
        end
        else
        begin
            dec_bits++;
            if (dec_bits == WORD_BITS)
            begin
                check_ws(i2so_ws, (dec_chan == LEFT) ? RIGHT : LEFT); // ws flipped on the LSB
                if (dec_chan == LEFT)
                    dec_lft = dec_sr;
                else
                begin
                    dec_lft_q.push_back(dec_lft);
                    dec_rgt_q.push_back(dec_sr);
                end
                dec_chan = (dec_chan == LEFT) ? RIGHT : LEFT;
                dec_bits = 0;
            end
            else
                check_ws(i2so_ws, dec_chan);
        end
        dec_ws_prev = i2so_ws;
    end

    task automatic wait_frame(input int frame);
        int waited;
        waited = 0;
        while (dec_rgt_q.size() == 0)
        begin
            @(posedge clk);
            waited++;
            if (waited > FRAME_WAIT)
            begin
                $display("timeout: output frame %0d did not arrive within 200 bit clocks", frame);
                $display("Simulation failed");
                $fatal(1);
            end
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial
    begin
        int          frame;
        int          live;
        audio_word_t got_l;
        audio_word_t got_r;
        audio_word_t exp_l;
        audio_word_t exp_r;

        void'($urandom(32'haf8a));
        i2si_sck = 1'b0;
        i2si_ws  = 1'b1;                                // Start in mid-frame
        i2si_sd  = 1'b0;
        rst_n    = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        // Idle outputs before any bit clock
        check_bit("i2so_sd", i2so_sd, 1'b0);
        check_ws(i2so_ws, LEFT);

        fork
            stream_audio();
        join_none

        frame = 0;
        live  = 0;
        while (live < NUM_LIVE)
        begin
            wait_frame(frame);
            got_l = dec_lft_q.pop_front();
            got_r = dec_rgt_q.pop_front();
            if ((first_live < 0) && ((got_l != '0) || (got_r != '0)))
                first_live = frame;                     // Audio phase found
            if ((first_live < 0) && (frame >= MAX_SILENT))
            begin
                $display("no audio reached the output within %0d frames", MAX_SILENT);
                $display("Simulation failed");
                $fatal(1);
            end
            expected_pair(frame, exp_l, exp_r);
            check_word("i2so_sd left", got_l, exp_l);
            check_word("i2so_sd right", got_r, exp_r);
            if (first_live >= 0)
                live++;
            frame++;
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: verilog/i2s_passthrough_top.sv
module i2s_passthrough_top (
    input  logic clk,
    input  logic rst_n,
    input  logic i2si_sck,                              // Codec bit clock in
    input  logic i2si_ws,
    input  logic i2si_sd,
    output logic i2so_sck,                              // Synced bit clock back out
    output logic i2so_ws,
    output logic i2so_sd
);

    import i2s_pkg::*;

    logic        sck_rise;
    logic        ws_s;
    logic        sd_s;
    logic        push;
    audio_word_t push_lft;
    audio_word_t push_rgt;

    sample_fetch_if fetch_bus ();                       // Buffer head to transmitter

    ////////////////////
    // Receive side
    ////////////////////

    i2s_sync u_sync (
        .clk      (clk),
        .rst_n    (rst_n),
        .i2si_sck (i2si_sck),
        .i2si_ws  (i2si_ws),
        .i2si_sd  (i2si_sd),
        .sck_s    (i2so_sck),
        .ws_s     (ws_s),
        .sd_s     (sd_s),
        .sck_rise (sck_rise)
    );

    i2s_deserializer u_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .sck_rise (sck_rise),
        .ws_s     (ws_s),
        .sd_s     (sd_s),
        .push     (push),
        .push_lft (push_lft),
        .push_rgt (push_rgt)
    );

    ////////////////////
    // Buffer and transmit side
    ////////////////////

    sample_fifo u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (push),
        .push_lft (push_lft),
        .push_rgt (push_rgt),
        .fetch    (fetch_bus.buffer)
    );

    serializer u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .sck_rise (sck_rise),                           // Same edge drives rx and tx
        .fetch    (fetch_bus.transmitter),
        .i2so_sd  (i2so_sd),
        .i2so_ws  (i2so_ws)
    );

endmodule

// File: verilog/serializer.sv
module serializer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sck_rise,              // Advance one bit
    sample_fetch_if.transmitter  fetch,
    output logic                 i2so_sd,
    output logic                 i2so_ws
);

    import i2s_pkg::*;

    channel_e    chan;                                  // Word on the wire
    bit_idx_t    bit_idx;                               // Bit sent at next sck_rise
    audio_word_t lft_data;                              // Current frame, left
    audio_word_t rgt_data;                              // Current frame, right
    logic        frame_end;                             // Right LSB goes out now
    logic        fetch_due;                             // Cycle after frame_end

    assign frame_end  = sck_rise && (chan == RIGHT) && (bit_idx == '0);
    assign fetch.take = fetch_due && fetch.avail;       // Only pop what is there

    ////////////////////
    // Bit and channel count
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            chan      <= LEFT;
            bit_idx   <= bit_idx_t'(WORD_BITS - 1);     // MSB first
            fetch_due <= 1'b0;
            i2so_sd   <= 1'b0;
            i2so_ws   <= 1'b0;
        end
        else
        begin
            fetch_due <= frame_end;
            if (sck_rise)
            begin
                // Bit for this edge from the word in progress
                if (chan == LEFT)
                    i2so_sd <= lft_data[bit_idx];
                else
                    i2so_sd <= rgt_data[bit_idx];

                if (bit_idx == '0)
                begin
                    bit_idx <= bit_idx_t'(WORD_BITS - 1);
                    chan    <= (chan == LEFT) ? RIGHT : LEFT;
                    i2so_ws <= (chan == LEFT);          // ws flips with the LSB
                end
                else
                begin
                    bit_idx <= bit_idx - 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Frame load
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            lft_data <= '0;                             // First frame is silent
            rgt_data <= '0;
        end
        else if (fetch_due)
        begin
            // Empty buffer gives a silent frame
            lft_data <= fetch.avail ? fetch.lft : '0;
            rgt_data <= fetch.avail ? fetch.rgt : '0;
        end
    end

    // Pop lands on the wrap to the left MSB before that bit goes out
    a_take_at_frame: assert property (@(posedge clk) disable iff (!rst_n)
        fetch.take |-> (!sck_rise && (chan == LEFT)
                        && (bit_idx == bit_idx_t'(WORD_BITS - 1))))
        else $error("take outside frame boundary");

endmodule

// File: verilog/sample_fifo.sv
module sample_fifo (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,                  // Write strobe, no back-pressure
    input  i2s_pkg::audio_word_t push_lft,
    input  i2s_pkg::audio_word_t push_rgt,
    sample_fetch_if.buffer       fetch
);

    import i2s_pkg::*;

    audio_word_t lft_mem [FIFO_DEPTH];                  // Left words of queued pairs
    audio_word_t rgt_mem [FIFO_DEPTH];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;                                // Points at head pair
    fifo_cnt_t   count;

    // Circular step
    function automatic fifo_ptr_t ptr_next(input fifo_ptr_t ptr);
        return (ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            lft_mem[wr_ptr] <= push_lft;
            rgt_mem[wr_ptr] <= push_rgt;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (fetch.take)
                rd_ptr <= ptr_next(rd_ptr);
            // Simultaneous push and take leaves count alone
            if (push && !fetch.take)
                count <= count + 1'b1;
            else if (fetch.take && !push)
                count <= count - 1'b1;
        end
    end

    // Show-ahead head pair
    assign fetch.avail = (count != '0);
    assign fetch.lft   = lft_mem[rd_ptr];
    assign fetch.rgt   = rgt_mem[rd_ptr];

    // Rx and tx share one bit clock, so the buffer never fills
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (count != fifo_cnt_t'(FIFO_DEPTH)))
        else $error("push into full sample buffer");

    a_take_avail: assert property (@(posedge clk) disable iff (!rst_n)
        fetch.take |-> fetch.avail)
        else $error("take from empty sample buffer");

endmodule

// File: verilog/i2s_deserializer.sv
module i2s_deserializer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sck_rise,               // Sample point for ws_s and sd_s
    input  logic                ws_s,
    input  logic                sd_s,
    output logic                push,                   // Pair complete strobe
    output i2s_pkg::audio_word_t push_lft,
    output i2s_pkg::audio_word_t push_rgt
);

    import i2s_pkg::*;

    rx_state_e   state;
    channel_e    chan;                                  // Word being collected
    bit_idx_t    bit_idx;                               // Bit expected on next sck_rise
    audio_word_t shreg;                                 // Shift register, MSB first
    logic        ws_prev;                               // ws at previous sck_rise
    logic        ws_edge;
    logic        ws_fall;
    logic        word_done;                             // LSB arrives on this sck_rise
    audio_word_t word_next;

    assign ws_edge   = ws_s ^ ws_prev;
    assign ws_fall   = ws_prev & ~ws_s;                 // Right LSB, left MSB follows
    assign word_next = {shreg[WORD_BITS-2:0], sd_s};
    assign word_done = (state == RECEIVE) && (bit_idx == '0);

    ////////////////////
    // Lock and bit count
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= HUNT;
            chan    <= LEFT;
            bit_idx <= bit_idx_t'(WORD_BITS - 1);
            ws_prev <= 1'b0;
            push    <= 1'b0;
        end
        else
        begin
            push <= 1'b0;                               // Single cycle strobe
            if (sck_rise)
            begin
                ws_prev <= ws_s;
                case (state)
                    HUNT:
                    begin
                        if (ws_fall)
                        begin
                            state   <= RECEIVE;
                            chan    <= LEFT;
                            bit_idx <= bit_idx_t'(WORD_BITS - 1);
                        end
                    end
                    RECEIVE:
                    begin
                        // ws change marks the LSB, MSB comes next
                        if (ws_edge)
                            bit_idx <= bit_idx_t'(WORD_BITS - 1);
                        else
                            bit_idx <= bit_idx - 1'b1;
                        if (word_done)
                        begin
                            chan <= (chan == LEFT) ? RIGHT : LEFT;
                            push <= (chan == RIGHT); // Right done, pair complete
                        end
                    end
                    default: state <= HUNT;
                endcase
            end
        end
    end

    // Payload path
    always_ff @(posedge clk)
    begin
        if (sck_rise && (state == RECEIVE))
        begin
            shreg <= word_next;
            if (word_done && (chan == LEFT))
                push_lft <= word_next;                  // Held until right completes
            if (word_done && (chan == RIGHT))
                push_rgt <= word_next;
        end
    end

    // Framing from the codec must keep ws changes on word boundaries
    a_ws_on_lsb: assert property (@(posedge clk) disable iff (!rst_n)
        (sck_rise && (state == RECEIVE) && ws_edge) |-> (bit_idx == '0))
        else $error("ws changed in mid-word, bit_idx %0d", bit_idx);

endmodule

// File: verilog/i2s_sync.sv
module i2s_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic i2si_sck,                              // Async bit clock from codec
    input  logic i2si_ws,                               // Async word select
    input  logic i2si_sd,                               // Async serial data
    output logic sck_s,                                 // Bit clock after two flops
    output logic ws_s,                                  // Word select, aligned to sck_rise
    output logic sd_s,                                  // Serial data, aligned to sck_rise
    output logic sck_rise                               // One pulse per bit clock rise
);

    logic [2:0] sck_ff;                                 // Two sync stages plus edge stage
    logic [2:0] ws_ff;
    logic [2:0] sd_ff;

    ////////////////////
    // Sync chains
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_ff   <= '0;
            ws_ff    <= '0;
            sd_ff    <= '0;
            sck_rise <= 1'b0;
        end
        else
        begin
            sck_ff   <= {sck_ff[1:0], i2si_sck};
            ws_ff    <= {ws_ff[1:0], i2si_ws};      // Same depth as the edge pulse
            sd_ff    <= {sd_ff[1:0], i2si_sd};
            sck_rise <= sck_ff[1] & ~sck_ff[2];     // Low to high on synced clock
        end
    end

    assign sck_s = sck_ff[1];
    // Third stage so ws and sd line up with sck_rise
    assign ws_s  = ws_ff[2];
    assign sd_s  = sd_ff[2];

endmodule

// File: verilog/sample_fetch_if.sv
// Head-of-buffer fetch path, buffer to transmitter
interface sample_fetch_if;

    import i2s_pkg::*;

    logic        avail;                                 // Buffer holds at least one pair
    audio_word_t lft;                                   // Head pair, left word
    audio_word_t rgt;                                   // Head pair, right word
    logic        take;                                  // Pops the head pair

    // Buffer side shows the head and accepts pops
    modport buffer (
        output avail,
        output lft,
        output rgt,
        input  take
    );

    // Transmitter side reads the head and pops it
    modport transmitter (
        input  avail,
        input  lft,
        input  rgt,
        output take
    );

endinterface

// File: verilog/i2s_pkg.sv
package i2s_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    localparam int WORD_BITS  = 16;                     // Bits per channel word
    localparam int FIFO_DEPTH = 4;                      // Stereo pairs in the buffer

    ////////////////////
    // Vector types
    ////////////////////

    typedef logic [WORD_BITS-1:0] audio_word_t;         // One channel sample, two's complement
    typedef logic [3:0]           bit_idx_t;            // Bit position inside a word

    // Buffer pointer and occupancy
    typedef logic [$clog2(FIFO_DEPTH)-1:0]   fifo_ptr_t;
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_cnt_t; // Holds 0 to FIFO_DEPTH

    ////////////////////
    // State encodings
    ////////////////////

    // Which word of the frame is on the wire
    typedef enum logic {
        LEFT  = 1'b0,                                   // Word select low
        RIGHT = 1'b1                                    // Word select high
    } channel_e;

    // Receiver frame lock
    typedef enum logic {
        HUNT    = 1'b0,                                 // Waiting for a ws fall
        RECEIVE = 1'b1                                  // Locked to frame
    } rx_state_e;

endpackage
